//--- common/rs_pkg.sv
// shared widths, encodings and packet types for the reservation station
// and its issue logic; modules import this inside their bodies
`default_nettype none

package rs_pkg;

    // ==================================================
    // machine sizes
    // ==================================================
    localparam int unsigned PHYS_REGS = 64;
    localparam int unsigned ROB_DEPTH = 32;
    localparam int unsigned XLEN      = 32;
    localparam int unsigned FU_TYPES  = 4;

    // derived index widths
    localparam int unsigned TAG_W = $clog2(PHYS_REGS);
    localparam int unsigned ROB_W = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] phys_tag_t;
    typedef logic [ROB_W-1:0] rob_idx_t;
    // architectural register index
    typedef logic [4:0]       arch_reg_t;

    // ==================================================
    // encodings
    // ==================================================
    // one issue port per kind
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SLTU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    // where operand b comes from
    typedef enum logic [1:0] {
        OPB_REG   = 2'd0,
        OPB_IMM_I = 2'd1,
        OPB_IMM_U = 2'd2
    } opb_sel_e;

    // ==================================================
    // instruction word, read as I or U format
    // ==================================================
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_word_u;

    // ==================================================
    // packets
    // ==================================================
    // renamed instruction from dispatch
    typedef struct packed {
        inst_word_u inst;
        alu_func_e  alu_func;
        fu_type_e   fu_type;
        opb_sel_e   opb_sel;
        arch_reg_t  dest_reg_idx;
        phys_tag_t  dest_tag;
        phys_tag_t  src1_tag;
        logic       src1_ready;
        phys_tag_t  src2_tag;
        logic       src2_ready;
        rob_idx_t   rob_idx;
    } disp_pkt_t;

    // stored slot contents
    typedef struct packed {
        logic      valid;
        disp_pkt_t pkt;
    } rs_entry_t;

    // what a functional unit receives
    typedef struct packed {
        logic            valid;
        alu_func_e       alu_func;
        phys_tag_t       dest_tag;
        phys_tag_t       src1_tag;
        phys_tag_t       src2_tag;
        rob_idx_t        rob_idx;
        opb_sel_e        opb_sel;
        logic [XLEN-1:0] imm;
    } issue_pkt_t;

endpackage

`default_nettype wire

//--- rs/rs_alloc_select.sv
// dispatch allocator; gives each valid dispatch slot the next lowest
// empty entry and reports how many entries are free (saturated)
`timescale 1ns/100ps
`default_nettype none

module rs_alloc_select #(
    parameter int unsigned RS_DEPTH       = 16,
    parameter int unsigned DISPATCH_WIDTH = 2
)(
    input  wire logic [RS_DEPTH-1:0]                     empty_i,
    input  wire logic [DISPATCH_WIDTH-1:0]               disp_valid_i,
    // one-hot entry choice per dispatch slot
    output logic      [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant_o,
    output logic      [$clog2(DISPATCH_WIDTH+1)-1:0]     free_slots_o
);
    localparam int unsigned CNT_W = $clog2(DISPATCH_WIDTH+1);

    // ==================================================
    // slot to entry grant
    // ==================================================
    always_comb begin : grant_walk
        logic [RS_DEPTH-1:0] avail;
        logic                found;
        avail   = empty_i;
        grant_o = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            found = 1'b0;
            // idle slot takes nothing
            if (disp_valid_i[k]) begin
                for (int j = 0; j < RS_DEPTH; j++) begin
                    if (!found && avail[j]) begin
                        found         = 1'b1;
                        grant_o[k][j] = 1'b1;
                        avail[j]      = 1'b0;
                    end
                end
            end
        end
    end

    // ==================================================
    // free count for dispatch
    // ==================================================
    always_comb begin : free_count
        int unsigned cnt;
        cnt = 0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            // stop counting at dispatch width
            if (empty_i[j] && (cnt < DISPATCH_WIDTH)) cnt++;
        end
        free_slots_o = CNT_W'(cnt);
    end

endmodule

`default_nettype wire

//--- rs/rs_entry.sv
// one reservation station slot; holds a renamed instruction, wakes its
// sources from the CDB tags and reports empty and ready to the station
`timescale 1ns/100ps
`default_nettype none

module rs_entry #(
    parameter int unsigned CDB_WIDTH = 2
)(
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 flush_i,
    // load from dispatch
    input  wire logic                                 disp_en_i,
    input  wire rs_pkg::disp_pkt_t                    disp_pkt_i,
    // leave the station this edge
    input  wire logic                                 issue_i,
    // tag broadcasts
    input  wire logic              [CDB_WIDTH-1:0]    cdb_valid_i,
    input  wire rs_pkg::phys_tag_t [CDB_WIDTH-1:0]    cdb_tag_i,
    output logic                                      empty_o,
    output rs_pkg::rs_entry_t                         entry_o,
    output logic                                      ready_o
);
    import rs_pkg::*;

    rs_entry_t entry_q;
    disp_pkt_t load_pkt;

    // tag hits for the incoming packet and for the held one
    logic disp_s1_hit;
    logic disp_s2_hit;
    logic held_s1_hit;
    logic held_s2_hit;

    // ==================================================
    // wakeup compare
    // ==================================================
    always_comb begin : tag_match
        disp_s1_hit = 1'b0;
        disp_s2_hit = 1'b0;
        held_s1_hit = 1'b0;
        held_s2_hit = 1'b0;
        for (int b = 0; b < CDB_WIDTH; b++) begin
            if (cdb_valid_i[b]) begin
                // same-cycle broadcast must not be missed on load
                if (cdb_tag_i[b] == disp_pkt_i.src1_tag) disp_s1_hit = 1'b1;
                if (cdb_tag_i[b] == disp_pkt_i.src2_tag) disp_s2_hit = 1'b1;
                if (cdb_tag_i[b] == entry_q.pkt.src1_tag) held_s1_hit = 1'b1;
                if (cdb_tag_i[b] == entry_q.pkt.src2_tag) held_s2_hit = 1'b1;
            end
        end
    end

    // packet as written on dispatch, ready bits merged with hits
    always_comb begin : load_merge
        load_pkt            = disp_pkt_i;
        load_pkt.src1_ready = disp_pkt_i.src1_ready | disp_s1_hit;
        load_pkt.src2_ready = disp_pkt_i.src2_ready | disp_s2_hit;
    end

    // ==================================================
    // slot state
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            // flush also drops a dispatch in the same cycle
            entry_q.valid <= 1'b0;
        end else if (disp_en_i) begin
            entry_q.valid <= 1'b1;
            entry_q.pkt   <= load_pkt;
        end else if (issue_i) begin
            entry_q.valid <= 1'b0;
        end else if (entry_q.valid) begin
            // sticky ready bits
            entry_q.pkt.src1_ready <= entry_q.pkt.src1_ready | held_s1_hit;
            entry_q.pkt.src2_ready <= entry_q.pkt.src2_ready | held_s2_hit;
        end
    end

    // ==================================================
    // status
    // ==================================================
    assign empty_o = ~entry_q.valid;
    assign entry_o = entry_q;
    // both operands available
    assign ready_o = entry_q.valid & entry_q.pkt.src1_ready & entry_q.pkt.src2_ready;

endmodule

`default_nettype wire

//--- rs/rs_station.sv
// reservation station body; array of entries plus the dispatch allocator
// entries and ready bits go out to the issue selector, issue strobes come back
`timescale 1ns/100ps
`default_nettype none

module rs_station #(
    parameter int unsigned RS_DEPTH       = 16,
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned CDB_WIDTH      = 2
)(
    input  wire logic                                     clock,
    input  wire logic                                     reset,
    input  wire logic                                     flush_i,

    // ==================================================
    // dispatch
    // ==================================================
    input  wire logic              [DISPATCH_WIDTH-1:0]   disp_valid_i,
    input  wire rs_pkg::disp_pkt_t [DISPATCH_WIDTH-1:0]   disp_pkt_i,

    // ==================================================
    // CDB
    // ==================================================
    input  wire logic              [CDB_WIDTH-1:0]        cdb_valid_i,
    input  wire rs_pkg::phys_tag_t [CDB_WIDTH-1:0]        cdb_tag_i,

    // ==================================================
    // issue selector
    // ==================================================
    input  wire logic              [RS_DEPTH-1:0]         issue_i,
    output rs_pkg::rs_entry_t      [RS_DEPTH-1:0]         entries_o,
    output logic                   [RS_DEPTH-1:0]         ready_o,

    // back to dispatch
    output logic                   [$clog2(DISPATCH_WIDTH+1)-1:0] free_slots_o,
    output logic                                          rs_full_o
);
    import rs_pkg::*;

    logic      [RS_DEPTH-1:0]                     empty;
    logic      [RS_DEPTH-1:0]                     disp_en;
    disp_pkt_t [RS_DEPTH-1:0]                     entry_pkt;
    logic      [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant;

    // ==================================================
    // entry array
    // ==================================================
    for (genvar e = 0; e < RS_DEPTH; e++) begin : g_entry
        rs_entry #(
            .CDB_WIDTH (CDB_WIDTH)
        ) u_entry (
            .clock       (clock),
            .reset       (reset),
            .flush_i     (flush_i),
            .disp_en_i   (disp_en[e]),
            .disp_pkt_i  (entry_pkt[e]),
            .issue_i     (issue_i[e]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .empty_o     (empty[e]),
            .entry_o     (entries_o[e]),
            .ready_o     (ready_o[e])
        );
    end

    // ==================================================
    // allocation
    // ==================================================
    rs_alloc_select #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) u_alloc (
        .empty_i      (empty),
        .disp_valid_i (disp_valid_i),
        .grant_o      (grant),
        .free_slots_o (free_slots_o)
    );

    // route each granted slot's packet to its entry
    always_comb begin : steer
        entry_pkt = '0;
        disp_en   = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (grant[k][j]) begin
                    entry_pkt[j] = disp_pkt_i[k];
                    disp_en[j]   = 1'b1;
                end
            end
        end
    end

    // full when nothing is empty
    assign rs_full_o = ~|empty;

endmodule

`default_nettype wire

//--- rtl/issue_select.sv
// issue selector; per functional unit type, picks the lowest ready entry,
// builds the issue packet with its immediate and strobes the entry out
`timescale 1ns/100ps
`default_nettype none

module issue_select #(
    parameter int unsigned RS_DEPTH = 16
)(
    input  wire rs_pkg::rs_entry_t  [RS_DEPTH-1:0]         entries_i,
    input  wire logic               [RS_DEPTH-1:0]         ready_i,
    // one busy level per unit type
    input  wire logic               [rs_pkg::FU_TYPES-1:0] fu_busy_i,
    output rs_pkg::issue_pkt_t      [rs_pkg::FU_TYPES-1:0] issue_o,
    // back to the station, at most one bit per type
    output logic                    [RS_DEPTH-1:0]         issue_en_o
);
    import rs_pkg::*;

    // ==================================================
    // operand-b immediate
    // ==================================================
    function automatic logic [XLEN-1:0] decode_imm(input disp_pkt_t p);
        logic [XLEN-1:0] i_ext;
        logic [XLEN-1:0] u_ext;
        i_ext = {{(XLEN-12){p.inst.i.imm[11]}}, p.inst.i.imm};
        // upper immediate lands in bits 31:12
        u_ext = {{(XLEN-20){p.inst.u.imm[19]}}, p.inst.u.imm};
        u_ext = u_ext << 12;
        case (p.opb_sel)
            OPB_IMM_I: decode_imm = i_ext;
            OPB_IMM_U: decode_imm = u_ext;
            default:   decode_imm = '0;
        endcase
    endfunction

    function automatic issue_pkt_t build_issue(input disp_pkt_t p);
        issue_pkt_t o;
        o          = '0;
        o.valid    = 1'b1;
        o.alu_func = p.alu_func;
        o.dest_tag = p.dest_tag;
        o.src1_tag = p.src1_tag;
        o.src2_tag = p.src2_tag;
        o.rob_idx  = p.rob_idx;
        o.opb_sel  = p.opb_sel;
        o.imm      = decode_imm(p);
        return o;
    endfunction

    // ==================================================
    // per-type pick, lowest index wins
    // ==================================================
    always_comb begin : pick
        logic found;
        issue_o    = '0;
        issue_en_o = '0;
        for (int t = 0; t < FU_TYPES; t++) begin
            found = 1'b0;
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (!found && ready_i[j] && (entries_i[j].pkt.fu_type == fu_type_e'(t))) begin
                    found = 1'b1;
                    // busy unit holds its oldest candidate in place
                    if (!fu_busy_i[t]) begin
                        issue_en_o[j] = 1'b1;
                        issue_o[t]    = build_issue(entries_i[j].pkt);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_issue_top.sv
// top of the station and issue path; sets the sizes and passes them down
// dispatch, CDB and unit busy come in, one issue packet per unit type goes out
`timescale 1ns/100ps
`default_nettype none

module rs_issue_top #(
    parameter int unsigned RS_DEPTH       = 16,
    parameter int unsigned DISPATCH_WIDTH = 2,
    parameter int unsigned CDB_WIDTH      = 2
)(
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire logic                                          flush_i,
    // dispatch
    input  wire logic               [DISPATCH_WIDTH-1:0]       disp_valid_i,
    input  wire rs_pkg::disp_pkt_t  [DISPATCH_WIDTH-1:0]       disp_pkt_i,
    output logic                    [$clog2(DISPATCH_WIDTH+1)-1:0] free_slots_o,
    output logic                                               rs_full_o,
    // CDB
    input  wire logic               [CDB_WIDTH-1:0]            cdb_valid_i,
    input  wire rs_pkg::phys_tag_t  [CDB_WIDTH-1:0]            cdb_tag_i,
    // functional units
    input  wire logic               [rs_pkg::FU_TYPES-1:0]     fu_busy_i,
    output rs_pkg::issue_pkt_t      [rs_pkg::FU_TYPES-1:0]     issue_o
);
    import rs_pkg::*;

    // station to selector
    rs_entry_t [RS_DEPTH-1:0] entries;
    logic      [RS_DEPTH-1:0] ready;
    logic      [RS_DEPTH-1:0] issue_en;

    // ==================================================
    // station
    // ==================================================
    rs_station #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) u_station (
        .clock        (clock),
        .reset        (reset),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_pkt_i   (disp_pkt_i),
        .cdb_valid_i  (cdb_valid_i),
        .cdb_tag_i    (cdb_tag_i),
        .issue_i      (issue_en),
        .entries_o    (entries),
        .ready_o      (ready),
        .free_slots_o (free_slots_o),
        .rs_full_o    (rs_full_o)
    );

    // ==================================================
    // issue selection
    // ==================================================
    issue_select #(
        .RS_DEPTH (RS_DEPTH)
    ) u_issue (
        .entries_i  (entries),
        .ready_i    (ready),
        .fu_busy_i  (fu_busy_i),
        .issue_o    (issue_o),
        .issue_en_o (issue_en)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile the reservation station testbench with Verilator and run it
# exit status is zero only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f sim.f --top-module rs_tb -Mdir obj_dir -o rs_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/rs_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim.f
+incdir+verification
common/rs_pkg.sv
rs/rs_entry.sv
rs/rs_alloc_select.sv
rs/rs_station.sv
rtl/issue_select.sv
rtl/rs_issue_top.sv
verification/rs_tb.sv

//--- verification/rs_tb_tasks.svh
// stimulus helpers, the compare task and the directed tests of rs_tb
// included inside the rs_tb module body, after its signal declarations
`ifndef RS_TB_TASKS_SVH
`define RS_TB_TASKS_SVH

// ==================================================
// stimulus
// ==================================================
// one edge forward, single-cycle strobes drop
task automatic next_cycle();
    @(posedge clock);
    disp_valid <= '0;
    cdb_valid  <= '0;
    flush      <= 1'b0;
endtask

task automatic drive_dispatch(input int slot, input disp_pkt_t pkt);
    disp_valid[slot] <= 1'b1;
    disp_pkt[slot]   <= pkt;
endtask

task automatic drive_cdb(input int bus, input phys_tag_t tag);
    cdb_valid[bus] <= 1'b1;
    cdb_tag[bus]   <= tag;
endtask

function automatic phys_tag_t rand_tag();
    return phys_tag_t'($urandom);
endfunction

// renamed instruction with a random word, function and dest
function automatic disp_pkt_t make_pkt(input fu_type_e fu, input opb_sel_e opb,
                                       input phys_tag_t s1, input logic r1,
                                       input phys_tag_t s2, input logic r2, input int rob);
    disp_pkt_t p;
    p              = '0;
    p.inst         = $urandom;
    p.alu_func     = alu_func_e'(4'($urandom_range(9, 0)));
    p.fu_type      = fu;
    p.opb_sel      = opb;
    p.dest_reg_idx = arch_reg_t'($urandom);
    p.dest_tag     = rand_tag();
    p.src1_tag     = s1;
    p.src1_ready   = r1;
    p.src2_tag     = s2;
    p.src2_ready   = r2;
    p.rob_idx      = rob_idx_t'(rob);
    return p;
endfunction

// I: sign-extended bits 31:20, U: bits 31:12 in the upper part
function automatic logic [31:0] expected_imm(input opb_sel_e sel, input logic [31:0] word);
    case (sel)
        OPB_IMM_I: return {{20{word[31]}}, word[31:20]};
        OPB_IMM_U: return {word[31:12], 12'h000};
        default:   return 32'h0;
    endcase
endfunction

// ==================================================
// checks
// ==================================================
task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("mismatch in %s, %s: expected %0h, actual %0h",
                 test_name, what, expected, actual);
    end
endtask

task automatic check_status(input int free_exp, input logic full_exp);
    check_value("free_slots", 32'(free_exp), 32'(free_slots));
    check_value("rs_full", 32'(full_exp), 32'(rs_full));
endtask

task automatic expect_issue(input fu_type_e fu, input disp_pkt_t p);
    issue_pkt_t got;
    string      port;
    got  = issue[fu];
    port = $sformatf("port %0d", fu);
    check_value({port, " valid"}, 32'd1, 32'(got.valid));
    check_value({port, " alu_func"}, 32'(p.alu_func), 32'(got.alu_func));
    check_value({port, " dest_tag"}, 32'(p.dest_tag), 32'(got.dest_tag));
    check_value({port, " src1_tag"}, 32'(p.src1_tag), 32'(got.src1_tag));
    check_value({port, " src2_tag"}, 32'(p.src2_tag), 32'(got.src2_tag));
    check_value({port, " rob_idx"}, 32'(p.rob_idx), 32'(got.rob_idx));
    check_value({port, " opb_sel"}, 32'(p.opb_sel), 32'(got.opb_sel));
    check_value({port, " imm"}, expected_imm(p.opb_sel, p.inst), got.imm);
endtask

task automatic expect_idle(input fu_type_e fu);
    check_value($sformatf("port %0d valid", fu), 32'd0, 32'(issue[fu].valid));
endtask

task automatic expect_all_idle();
    for (int t = 0; t < FU_TYPES; t++) begin
        expect_idle(fu_type_e'(2'(t)));
    end
endtask

// fill entry index, or -1 for a quiet port
task automatic expect_port(input fu_type_e fu, input int idx);
    if (idx < 0) begin
        expect_idle(fu);
    end else begin
        expect_issue(fu, fill_pkt[idx]);
    end
endtask

task automatic begin_test(input string name);
    test_name     = name;
    test_err_base = error_count;
endtask

task automatic end_test();
    test_count++;
    $display("test %s finished with %0d errors", test_name, error_count - test_err_base);
endtask

// ==================================================
// directed tests
// ==================================================
task automatic reset_state_check();
    begin_test("reset_state");
    @(negedge clock);
    check_status(2, 1'b0);
    expect_all_idle();
    end_test();
endtask

// both ready, both out on their own ports one cycle later
task automatic dispatch_ready_pair(input fu_type_e fa, input opb_sel_e oa,
                                   input fu_type_e fb, input opb_sel_e ob, input int rob);
    disp_pkt_t a;
    disp_pkt_t b;
    a = make_pkt(fa, oa, rand_tag(), 1'b1, rand_tag(), 1'b1, rob);
    b = make_pkt(fb, ob, rand_tag(), 1'b1, rand_tag(), 1'b1, rob + 1);
    next_cycle();
    drive_dispatch(0, a);
    drive_dispatch(1, b);
    next_cycle();
    @(negedge clock);
    expect_issue(fa, a);
    expect_issue(fb, b);
endtask

task automatic issue_two_types();
    begin_test("issue_two_types");
    dispatch_ready_pair(FU_ALU, OPB_IMM_I, FU_MEM, OPB_IMM_U, 0);
    dispatch_ready_pair(FU_MULT, OPB_REG, FU_BRANCH, OPB_IMM_I, 2);
    // issued entries are gone, nothing repeats
    next_cycle();
    @(negedge clock);
    expect_all_idle();
    check_status(2, 1'b0);
    end_test();
endtask

task automatic wakeup_from_cdb();
    disp_pkt_t p;
    begin_test("wakeup_from_cdb");
    // source 1 waits on tag 10
    p = make_pkt(FU_ALU, OPB_IMM_I, 6'd10, 1'b0, rand_tag(), 1'b1, 4);
    next_cycle();
    drive_dispatch(0, p);
    repeat (3) begin
        next_cycle();
        @(negedge clock);
        expect_idle(FU_ALU);
    end
    next_cycle();
    drive_cdb(0, 6'd10);
    // broadcast not sampled yet
    @(negedge clock);
    expect_idle(FU_ALU);
    next_cycle();
    @(negedge clock);
    expect_issue(FU_ALU, p);
    // both sources woken in the dispatch cycle itself
    p = make_pkt(FU_BRANCH, OPB_IMM_U, 6'd11, 1'b0, 6'd12, 1'b0, 5);
    next_cycle();
    drive_dispatch(1, p);
    drive_cdb(1, 6'd11);
    drive_cdb(0, 6'd12);
    next_cycle();
    @(negedge clock);
    expect_issue(FU_BRANCH, p);
    next_cycle();
    @(negedge clock);
    expect_all_idle();
    end_test();
endtask

task automatic fill_and_drain();
    // per drain step, the entry seen on each port
    int alu_order  [5] = '{0, 1, 4, 5, -1};
    int mult_order [5] = '{-1, 2, 3, 6, 7};
    begin_test("fill_and_drain");
    // entries 0,1 and 4,5 ALU, 2,3 and 6,7 MULT, source 1 on tag 20+i
    for (int i = 0; i < RS_DEPTH; i++) begin
        fill_pkt[i] = make_pkt(fu_type_e'(2'((i / 2) % 2)), opb_sel_e'(2'(i % 3)),
                               phys_tag_t'(20 + i), 1'b0, rand_tag(), 1'b1, 8 + i);
    end
    for (int c = 0; c < RS_DEPTH / 2; c++) begin
        @(negedge clock);
        check_value("free_slots before dispatch", 32'd2, 32'(free_slots));
        next_cycle();
        drive_dispatch(0, fill_pkt[2 * c]);
        drive_dispatch(1, fill_pkt[2 * c + 1]);
    end
    next_cycle();
    @(negedge clock);
    check_status(0, 1'b1);
    expect_all_idle();
    // two tags per cycle, in dispatch order
    for (int k = 0; k <= 5; k++) begin
        next_cycle();
        if (k < 4) begin
            drive_cdb(0, phys_tag_t'(20 + 2 * k));
            drive_cdb(1, phys_tag_t'(21 + 2 * k));
        end
        @(negedge clock);
        if (k > 0) begin
            expect_port(FU_ALU, alu_order[k - 1]);
            expect_port(FU_MULT, mult_order[k - 1]);
        end else begin
            expect_all_idle();
        end
    end
    next_cycle();
    @(negedge clock);
    check_status(2, 1'b0);
    expect_all_idle();
    end_test();
endtask

task automatic busy_backpressure();
    disp_pkt_t a;
    disp_pkt_t b;
    begin_test("busy_backpressure");
    a = make_pkt(FU_MEM, OPB_IMM_I, rand_tag(), 1'b1, rand_tag(), 1'b1, 16);
    b = make_pkt(FU_ALU, OPB_IMM_U, rand_tag(), 1'b1, rand_tag(), 1'b1, 17);
    next_cycle();
    fu_busy[FU_MEM] <= 1'b1;
    drive_dispatch(0, a);
    drive_dispatch(1, b);
    next_cycle();
    @(negedge clock);
    expect_issue(FU_ALU, b);
    expect_idle(FU_MEM);
    repeat (2) begin
        next_cycle();
        @(negedge clock);
        expect_idle(FU_MEM);
    end
    // release; waiting entry goes out unchanged
    next_cycle();
    fu_busy[FU_MEM] <= 1'b0;
    @(negedge clock);
    expect_issue(FU_MEM, a);
    next_cycle();
    @(negedge clock);
    expect_all_idle();
    check_status(2, 1'b0);
    end_test();
endtask

task automatic flush_discards();
    disp_pkt_t c;
    begin_test("flush_discards");
    // eight waiters on tags 40 to 47
    for (int i = 0; i < RS_DEPTH; i += 2) begin
        next_cycle();
        drive_dispatch(0, make_pkt(FU_ALU, OPB_REG, phys_tag_t'(40 + i), 1'b0,
                                   rand_tag(), 1'b1, 24 + i));
        drive_dispatch(1, make_pkt(FU_BRANCH, OPB_IMM_I, phys_tag_t'(41 + i), 1'b0,
                                   rand_tag(), 1'b1, 25 + i));
    end
    next_cycle();
    flush <= 1'b1;
    @(negedge clock);
    check_status(0, 1'b1);
    next_cycle();
    @(negedge clock);
    check_status(2, 1'b0);
    // ready dispatch together with a flush is dropped
    c = make_pkt(FU_MULT, OPB_REG, rand_tag(), 1'b1, rand_tag(), 1'b1, 30);
    next_cycle();
    drive_dispatch(0, c);
    flush <= 1'b1;
    for (int i = 0; i < RS_DEPTH + 2; i += 2) begin
        next_cycle();
        if (i < RS_DEPTH) begin
            drive_cdb(0, phys_tag_t'(40 + i));
            drive_cdb(1, phys_tag_t'(41 + i));
        end
        @(negedge clock);
        expect_all_idle();
    end
    check_status(2, 1'b0);
    end_test();
endtask

`endif

//--- verification/rs_tb.sv
// testbench for the reservation station and issue path; stands in for
// dispatch, the CDB and the functional units, and checks the issue ports
`timescale 1ns/100ps
`default_nettype none

module rs_tb;
    import rs_pkg::*;

    localparam int unsigned RS_DEPTH       = 8;
    localparam int unsigned DISPATCH_WIDTH = 2;
    localparam int unsigned CDB_WIDTH      = 2;
    // tests need about 50 cycles, wide margin above that
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic                                    clock;
    logic                                    reset;
    logic                                    flush;
    logic       [DISPATCH_WIDTH-1:0]         disp_valid;
    disp_pkt_t  [DISPATCH_WIDTH-1:0]         disp_pkt;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0]     free_slots;
    logic                                    rs_full;
    logic       [CDB_WIDTH-1:0]              cdb_valid;
    phys_tag_t  [CDB_WIDTH-1:0]              cdb_tag;
    logic       [FU_TYPES-1:0]               fu_busy;
    issue_pkt_t [FU_TYPES-1:0]               issue;

    // run bookkeeping
    string       test_name;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned test_count;
    int unsigned test_err_base;
    int unsigned cycle_count;
    // packets of the fill test, index equals entry
    disp_pkt_t   fill_pkt [RS_DEPTH];

    // ==================================================
    // DUT
    // ==================================================
    rs_issue_top #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .flush_i      (flush),
        .disp_valid_i (disp_valid),
        .disp_pkt_i   (disp_pkt),
        .free_slots_o (free_slots),
        .rs_full_o    (rs_full),
        .cdb_valid_i  (cdb_valid),
        .cdb_tag_i    (cdb_tag),
        .fu_busy_i    (fu_busy),
        .issue_o      (issue)
    );

    // 4 ns period
    initial begin : clock_gen
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // cycle limit so a stuck run still ends
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    `include "rs_tb_tasks.svh"

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : run_tests
        void'($urandom(53));
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        // every DUT input starts known
        reset       = 1'b1;
        flush       = 1'b0;
        disp_valid  = '0;
        disp_pkt    = '0;
        cdb_valid   = '0;
        cdb_tag     = '0;
        fu_busy     = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        reset_state_check();
        issue_two_types();
        wakeup_from_cdb();
        fill_and_drain();
        busy_backpressure();
        flush_discards();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
